// File: sim.f
+incdir+.
mips_pkg.sv
mips_exec_if.sv
mips_reg_file.sv
mips_execute.sv
mips_sequencer.sv
mips_cpu_bus.sv
mips_cpu_checker.sv
tb_mips_cpu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_mips_cpu -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: tb_mips_cpu.sv
`timescale 1ns/10ps
`include "mips_macros.svh"

module tb_mips_cpu import mips_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 3;
    localparam int STALL_LIMIT = 4;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam word_t SEED = 32'd47883;
    localparam int V0 = `MIPS_V0_INDEX;
    // Words of the five test programs
    localparam int PROGRAM_WORDS = 16 + 7 + 12 + 4 + 16;
    // Fetch and data access both stalled, plus EXEC
    localparam int CYCLES_PER_INSTR = 2 * (STALL_LIMIT + 2) + 1;
    localparam int WATCHDOG_NS =
        2 * CLK_PERIOD * (PROGRAM_WORDS * CYCLES_PER_INSTR + 5 * (RESET_CYCLES + 2));

    logic                        clk = 1'b0;
    logic                        reset = 1'b1;
    logic                        waitrequest = 1'b1;
    logic [`MIPS_XLEN-1:0]       readdata = '0;
    logic                        active;
    logic [`MIPS_XLEN-1:0]       register_v0;
    logic [`MIPS_XLEN-1:0]       address;
    logic                        write;
    logic                        read;
    logic [`MIPS_XLEN-1:0]       writedata;
    logic [`MIPS_BYTE_LANES-1:0] byteenable;

    // Memory model state
    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    int    prog_len = 0;
    word_t write_addr_log[$];
    word_t write_data_log[$];
    logic  in_transfer = 1'b0;
    int    stall_left = 0;
    int    min_stall = 0;
    int    max_stall = 2;
    word_t stall_state = SEED;
    logic  first_read_seen = 1'b0;
    word_t first_read_addr = '0;
    logic  read_at_zero = 1'b0;

    // Operands shared by the ALU test and its stalled rerun
    word_t       op_state = SEED;
    word_t       op_a;
    word_t       op_b;
    logic [15:0] imm1;
    logic [15:0] imm2;
    logic [15:0] imm3;
    logic [15:0] imm4;

    mips_cpu_bus i_dut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t lcg(input word_t state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t read_word(input word_t addr);
        word_t offset;
        offset = addr - `MIPS_RESET_VECTOR;
        if (offset < IMEM_WORDS * 4) begin
            return imem[offset[7:2]];
        end
        if (addr < DMEM_WORDS * 4) begin
            return dmem[addr[7:2]];
        end
        return ~addr;
    endfunction

    // Avalon slave with a random number of wait cycles per access
    always @(posedge clk) begin
        if (reset) begin
            waitrequest <= 1'b1;
            in_transfer = 1'b0;
            first_read_seen = 1'b0;
            first_read_addr = '0;
            read_at_zero = 1'b0;
            write_addr_log.delete();
            write_data_log.delete();
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] = ~word_t'(i * 4);
            end
        end else if (!(read || write) || !waitrequest) begin
            // Idle, or the access completes on this edge
            if (write && !waitrequest) begin
                if (address < DMEM_WORDS * 4) begin
                    dmem[address[7:2]] = writedata;
                end
                write_addr_log.push_back(address);
                write_data_log.push_back(writedata);
            end
            waitrequest <= 1'b1;
            in_transfer = 1'b0;
        end else begin
            if (read && !first_read_seen) begin
                first_read_seen = 1'b1;
                first_read_addr = address;
            end
            if (read && (address == `MIPS_HALT_ADDR)) begin
                read_at_zero = 1'b1;
            end
            if (!in_transfer) begin
                in_transfer = 1'b1;
                stall_state = lcg(stall_state);
                stall_left = min_stall + int'(stall_state[23:16]) % (max_stall - min_stall + 1);
            end
            if (stall_left == 0) begin
                waitrequest <= 1'b0;
                readdata <= read_word(address);
            end else begin
                stall_left--;
            end
        end
    end

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    function automatic word_t encode_r(input int rs, input int rt, input int rd,
                                       input function_t fn);
        return {OPCODE_R, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t encode_i(input opcode_t op, input int rs, input int rt,
                                       input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic clear_program();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        prog_len = 0;
    endtask

    task automatic emit(input word_t instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    // JR through r0 halts after its delay slot
    task automatic emit_halt();
        emit(encode_r(0, 0, 0, FUNCTION_JR));
        emit(32'h0000_0000);
    endtask

    task automatic run_program(input string name);
        @(posedge clk);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value({name, " active after reset"}, 32'd1, word_t'(active));
        while (active) @(posedge clk);
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value({name, " active after halt"}, 32'd0, word_t'(active));
        check_value({name, " first read address"}, `MIPS_RESET_VECTOR, first_read_addr);
        check_value({name, " read at halt address"}, 32'd0, word_t'(read_at_zero));
    endtask

    task automatic draw_alu_operands();
        op_state = lcg(op_state);
        op_a = op_state;
        op_state = lcg(op_state);
        op_b = op_state;
        op_state = lcg(op_state);
        // Top bit set so ADDIU adds a negative value
        imm1 = op_state[31:16] | 16'h8000;
        imm2 = op_state[15:0];
        op_state = lcg(op_state);
        imm3 = op_state[31:16];
        imm4 = op_state[15:0];
    endtask

    function automatic word_t expected_alu();
        word_t sum;
        word_t diff;
        word_t mixed;
        word_t added;
        sum = op_a + op_b;
        diff = op_a - op_b;
        mixed = ((sum & diff) | op_a) ^ diff;
        added = mixed + {{16{imm1[15]}}, imm1};
        return (added ^ {16'h0000, imm3}) ^ ((mixed & {16'h0000, imm2}) | {16'h0000, imm4});
    endfunction

    task automatic alu_test(input string name);
        clear_program();
        emit(encode_i(OPCODE_LUI, 0, 8, op_a[31:16]));
        emit(encode_i(OPCODE_ORI, 8, 8, op_a[15:0]));
        emit(encode_i(OPCODE_LUI, 0, 9, op_b[31:16]));
        emit(encode_i(OPCODE_ORI, 9, 9, op_b[15:0]));
        emit(encode_r(8, 9, 10, FUNCTION_ADDU));
        emit(encode_r(8, 9, 11, FUNCTION_SUBU));
        emit(encode_r(10, 11, 12, FUNCTION_AND));
        emit(encode_r(12, 8, 13, FUNCTION_OR));
        emit(encode_r(13, 11, 14, FUNCTION_XOR));
        emit(encode_i(OPCODE_ADDIU, 14, 15, imm1));
        emit(encode_i(OPCODE_ANDI, 14, 16, imm2));
        emit(encode_i(OPCODE_XORI, 15, 17, imm3));
        emit(encode_i(OPCODE_ORI, 16, 18, imm4));
        emit(encode_r(17, 18, V0, FUNCTION_XOR));
        emit_halt();
        run_program(name);
        check_value({name, " v0"}, expected_alu(), register_v0);
    endtask

    task automatic load_store_test(input string name);
        word_t data;
        op_state = lcg(op_state);
        data = op_state;
        clear_program();
        emit(encode_i(OPCODE_LUI, 0, 8, data[31:16]));
        emit(encode_i(OPCODE_ORI, 8, 8, data[15:0]));
        emit(encode_i(OPCODE_ADDIU, 0, 9, 16'h0040));
        // Offset -4 from base 0x40
        emit(encode_i(OPCODE_SW, 9, 8, 16'hFFFC));
        emit(encode_i(OPCODE_LW, 9, V0, 16'hFFFC));
        emit_halt();
        run_program(name);
        check_value({name, " write count"}, 32'd1, word_t'(write_addr_log.size()));
        check_value({name, " write address"}, 32'h0000_003C, write_addr_log[0]);
        check_value({name, " write data"}, data, write_data_log[0]);
        check_value({name, " v0"}, data, register_v0);
    endtask

    task automatic branch_test(input string name);
        word_t j_target;
        j_target = `MIPS_RESET_VECTOR + 32'd40;
        clear_program();
        emit(encode_i(OPCODE_ADDIU, 0, 8, 16'd5));
        emit(encode_i(OPCODE_ADDIU, 0, 9, 16'd5));
        emit(encode_i(OPCODE_BEQ, 8, 9, 16'd2));
        emit(encode_i(OPCODE_ADDIU, V0, V0, 16'h0001));
        emit(encode_i(OPCODE_ADDIU, V0, V0, 16'h0100));
        // Not taken; its target is the word skipped by J
        emit(encode_i(OPCODE_BNE, 8, 9, 16'd3));
        emit(encode_i(OPCODE_ADDIU, V0, V0, 16'h0002));
        emit({OPCODE_J, j_target[27:2]});
        emit(encode_i(OPCODE_ADDIU, V0, V0, 16'h0004));
        emit(encode_i(OPCODE_ADDIU, V0, V0, 16'h0200));
        emit_halt();
        run_program(name);
        check_value({name, " v0"}, 32'd7, register_v0);
    endtask

    task automatic halt_test(input string name);
        clear_program();
        emit(encode_i(OPCODE_ADDIU, 0, V0, 16'h0055));
        emit(encode_r(0, 0, 0, FUNCTION_JR));
        emit(encode_i(OPCODE_ADDIU, V0, V0, 16'h000A));
        emit(encode_i(OPCODE_ADDIU, V0, V0, 16'h0300));
        run_program(name);
        check_value({name, " v0"}, 32'h0000_005F, register_v0);
    endtask

    initial begin
        draw_alu_operands();
        alu_test("alu");
        load_store_test("load_store");
        branch_test("branch_delay_slot");
        halt_test("halt");
        min_stall = 1;
        max_stall = STALL_LIMIT;
        alu_test("reset_and_stalls");
        if (i_dut.i_checker.violations == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation hung: the processor did not halt within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: mips_cpu_checker.sv
`timescale 1ns/10ps
`include "mips_macros.svh"

module mips_cpu_checker (
    input logic                        clk,
    input logic                        reset,
    input logic                        active,
    input logic                        read,
    input logic                        write,
    input logic                        waitrequest,
    input logic [`MIPS_XLEN-1:0]       address,
    input logic [`MIPS_XLEN-1:0]       writedata,
    input logic [`MIPS_BYTE_LANES-1:0] byteenable
);

    int violations = 0;

    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else begin
            $error("read and write are high together");
            violations++;
        end

    // A stalled request keeps its strobe, address and store data
    request_held: assert property (@(posedge clk) disable iff (reset)
        ((read || write) && waitrequest) |=> ($stable(read) && $stable(write)
            && $stable(address) && (!write || $stable(writedata))))
        else begin
            $error("request changed while waitrequest was high");
            violations++;
        end

    full_word_lanes: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> (byteenable == {`MIPS_BYTE_LANES{1'b1}}))
        else begin
            $error("byteenable is not all ones during an access");
            violations++;
        end

    halted_is_quiet: assert property (@(posedge clk) disable iff (reset)
        !active |=> (!active && !read && !write))
        else begin
            $error("bus activity or restart after halt");
            violations++;
        end

endmodule

bind mips_cpu_bus mips_cpu_checker i_checker (
    .clk         (clk),
    .reset       (reset),
    .active      (active),
    .read        (read),
    .write       (write),
    .waitrequest (waitrequest),
    .address     (address),
    .writedata   (writedata),
    .byteenable  (byteenable)
);

// File: mips_cpu_bus.sv
`timescale 1ns/10ps
`include "mips_macros.svh"

module mips_cpu_bus import mips_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        active,
    output logic [`MIPS_XLEN-1:0]       register_v0,

    // Avalon memory-mapped master
    output logic [`MIPS_XLEN-1:0]       address,
    output logic                        write,
    output logic                        read,
    input  logic                        waitrequest,
    output logic [`MIPS_XLEN-1:0]       writedata,
    output logic [`MIPS_BYTE_LANES-1:0] byteenable,
    input  logic [`MIPS_XLEN-1:0]       readdata
);

    mips_exec_if ex_if ();

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    logic      rf_wr_en;
    reg_addr_t rf_wr_addr;
    word_t     rf_wr_data;

    mips_sequencer i_sequencer (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .active      (active),
        .read        (read),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .ex          (ex_if.sequencer),
        .rf_wr_en    (rf_wr_en),
        .rf_wr_addr  (rf_wr_addr),
        .rf_wr_data  (rf_wr_data)
    );

    mips_execute i_execute (
        .ex      (ex_if.execute),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    mips_reg_file i_reg_file (
        .clk         (clk),
        .reset       (reset),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .wr_en       (rf_wr_en),
        .wr_addr     (rf_wr_addr),
        .wr_data     (rf_wr_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

endmodule

// File: mips_sequencer.sv
`timescale 1ns/10ps
`include "mips_macros.svh"

module mips_sequencer import mips_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        waitrequest,
    input  word_t                       readdata,
    output logic                        active,
    output logic                        read,
    output logic                        write,
    output word_t                       address,
    output word_t                       writedata,
    output logic [`MIPS_BYTE_LANES-1:0] byteenable,
    mips_exec_if.sequencer              ex,
    output logic                        rf_wr_en,
    output reg_addr_t                   rf_wr_addr,
    output word_t                       rf_wr_data
);

    state_t state;
    word_t  pc;
    word_t  ir;
    word_t  pending_target;
    logic   pending;
    logic   at_halt;

    assign at_halt = (pc == `MIPS_HALT_ADDR);

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= FETCH;
            pc      <= `MIPS_RESET_VECTOR;
            pending <= 1'b0;
            active  <= 1'b1;
        end else begin
            case (state)
                FETCH: begin
                    if (at_halt) begin
                        state  <= HALTED;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    // The delay slot target is used once, then dropped
                    pc      <= pending ? pending_target : pc + word_t'(4);
                    pending <= ex.jump_taken;
                    state   <= (ex.mem_read || ex.mem_write) ? MEM_ACCESS : FETCH;
                end
                MEM_ACCESS: begin
                    if (!waitrequest) begin
                        state <= FETCH;
                    end
                end
                HALTED: state <= HALTED;
                default: state <= FETCH;
            endcase
        end
    end

    // Instruction register and stored jump target
    always_ff @(posedge clk) begin
        if ((state == FETCH) && !at_halt && !waitrequest) begin
            ir <= readdata;
        end
        if ((state == EXEC) && ex.jump_taken) begin
            pending_target <= ex.jump_target;
        end
    end

    assign ex.instr = ir;
    assign ex.pc    = pc;

    // Avalon master outputs
    assign read = ((state == FETCH) && !at_halt) || ((state == MEM_ACCESS) && ex.mem_read);
    assign write      = (state == MEM_ACCESS) && ex.mem_write;
    assign address    = (state == MEM_ACCESS) ? ex.mem_addr : pc;
    assign writedata  = ex.store_data;
    assign byteenable = (read || write) ? '1 : '0;

    // ALU result at the end of EXEC, load data at the end of an LW access
    assign rf_wr_en = ((state == EXEC) && ex.wb_en)
                   || ((state == MEM_ACCESS) && ex.mem_read && !waitrequest);
    assign rf_wr_addr = (state == MEM_ACCESS) ? ex.load_addr : ex.wb_addr;
    assign rf_wr_data = (state == MEM_ACCESS) ? readdata : ex.wb_data;

endmodule

// File: mips_execute.sv
`timescale 1ns/10ps

module mips_execute import mips_pkg::*; (
    mips_exec_if.execute ex,
    output reg_addr_t    rs_addr,
    output reg_addr_t    rt_addr,
    input  word_t        rs_data,
    input  word_t        rt_data
);

    opcode_t   opcode;
    function_t funct;
    reg_addr_t rd_addr;
    logic [15:0] imm;
    logic [25:0] index;
    word_t     imm_sext;
    word_t     imm_zext;
    word_t     pc_plus4;
    word_t     branch_target;
    word_t     alu_result;
    logic      alu_writes;

    // Instruction fields
    assign opcode  = opcode_t'(ex.instr[31:26]);
    assign rs_addr = ex.instr[25:21];
    assign rt_addr = ex.instr[20:16];
    assign rd_addr = ex.instr[15:11];
    assign imm     = ex.instr[15:0];
    assign index   = ex.instr[25:0];
    assign funct   = function_t'(ex.instr[5:0]);

    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'h0000, imm};

    assign pc_plus4      = ex.pc + word_t'(4);
    assign branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};

    // ALU and control transfer; unknown encodings fall through as no-ops
    always_comb begin
        alu_result     = '0;
        alu_writes     = 1'b0;
        ex.jump_taken  = 1'b0;
        ex.jump_target = branch_target;
        case (opcode)
            OPCODE_R: begin
                alu_writes = 1'b1;
                case (funct)
                    FUNCTION_ADDU: alu_result = rs_data + rt_data;
                    FUNCTION_SUBU: alu_result = rs_data - rt_data;
                    FUNCTION_AND:  alu_result = rs_data & rt_data;
                    FUNCTION_OR:   alu_result = rs_data | rt_data;
                    FUNCTION_XOR:  alu_result = rs_data ^ rt_data;
                    FUNCTION_JR: begin
                        alu_writes     = 1'b0;
                        ex.jump_taken  = 1'b1;
                        ex.jump_target = rs_data;
                    end
                    default: alu_writes = 1'b0;
                endcase
            end
            OPCODE_ADDIU: begin
                alu_result = rs_data + imm_sext;
                alu_writes = 1'b1;
            end
            OPCODE_ANDI: begin
                alu_result = rs_data & imm_zext;
                alu_writes = 1'b1;
            end
            OPCODE_ORI: begin
                alu_result = rs_data | imm_zext;
                alu_writes = 1'b1;
            end
            OPCODE_XORI: begin
                alu_result = rs_data ^ imm_zext;
                alu_writes = 1'b1;
            end
            OPCODE_LUI: begin
                alu_result = {imm, 16'h0000};
                alu_writes = 1'b1;
            end
            OPCODE_BEQ: ex.jump_taken = (rs_data == rt_data);
            OPCODE_BNE: ex.jump_taken = (rs_data != rt_data);
            OPCODE_J: begin
                ex.jump_taken  = 1'b1;
                ex.jump_target = {pc_plus4[31:28], index, 2'b00};
            end
            default: ;
        endcase
    end

    assign ex.wb_addr = (opcode == OPCODE_R) ? rd_addr : rt_addr;
    assign ex.wb_en   = alu_writes && (ex.wb_addr != '0);
    assign ex.wb_data = alu_result;

    // Load and store
    assign ex.mem_read   = (opcode == OPCODE_LW);
    assign ex.mem_write  = (opcode == OPCODE_SW);
    assign ex.mem_addr   = rs_data + imm_sext;
    assign ex.store_data = rt_data;
    assign ex.load_addr  = rt_addr;

endmodule

// File: mips_reg_file.sv
`timescale 1ns/10ps
`include "mips_macros.svh"

module mips_reg_file import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rs_data,
    output word_t     rt_data,
    output word_t     register_v0
);

    word_t regs [`MIPS_REG_COUNT];

    // r0 is never written, so it reads back as zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data     = regs[rs_addr];
    assign rt_data     = regs[rt_addr];
    assign register_v0 = regs[`MIPS_V0_INDEX];

endmodule

// File: mips_exec_if.sv
`timescale 1ns/10ps

interface mips_exec_if import mips_pkg::*; ();

    // Sequencer side
    word_t     instr;
    word_t     pc;

    // Execute side is combinational from instr, pc and register data
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      mem_read;
    logic      mem_write;
    word_t     mem_addr;
    word_t     store_data;
    reg_addr_t load_addr;
    logic      jump_taken;
    word_t     jump_target;

    modport sequencer (
        output instr, pc,
        input  wb_en, wb_addr, wb_data, mem_read, mem_write, mem_addr,
        input  store_data, load_addr, jump_taken, jump_target
    );

    modport execute (
        input  instr, pc,
        output wb_en, wb_addr, wb_data, mem_read, mem_write, mem_addr,
        output store_data, load_addr, jump_taken, jump_target
    );

endinterface

// File: mips_pkg.sv
`include "mips_macros.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

    // Primary opcodes in the standard MIPS encodings
    typedef enum logic [5:0] {
        OPCODE_R     = 6'h00,
        OPCODE_J     = 6'h02,
        OPCODE_BEQ   = 6'h04,
        OPCODE_BNE   = 6'h05,
        OPCODE_ADDIU = 6'h09,
        OPCODE_ANDI  = 6'h0C,
        OPCODE_ORI   = 6'h0D,
        OPCODE_XORI  = 6'h0E,
        OPCODE_LUI   = 6'h0F,
        OPCODE_LW    = 6'h23,
        OPCODE_SW    = 6'h2B
    } opcode_t;

    // Function field of R-type instructions
    typedef enum logic [5:0] {
        FUNCTION_JR   = 6'h08,
        FUNCTION_ADDU = 6'h21,
        FUNCTION_SUBU = 6'h23,
        FUNCTION_AND  = 6'h24,
        FUNCTION_OR   = 6'h25,
        FUNCTION_XOR  = 6'h26
    } function_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM_ACCESS,
        HALTED
    } state_t;

endpackage

// File: mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Datapath and address width
`define MIPS_XLEN 32

// General-purpose register file geometry
`define MIPS_REG_COUNT 32
`define MIPS_REG_ADDR_W 5

// Avalon byte lanes per word
`define MIPS_BYTE_LANES 4

// First instruction fetch after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// Reaching this program counter stops the processor
`define MIPS_HALT_ADDR 32'h00000000

// Register exposed as register_v0
`define MIPS_V0_INDEX 2

`endif
